// ==== verilog/rvv_pkg.sv ====
package rvv_pkg;

  // Issue width and vector geometry
  localparam int NUM_SLOTS = 2;
  localparam int VLMAX = 4;
  localparam int NUM_VREGS = 8;
  localparam int VREG_IDX_W = 3;
  localparam int ELEM_W = 32;
  localparam int ELEM_IDX_W = 2;
  localparam int XREG_ADDR_W = 5;

  // Vector length holds 0 to VLMAX
  localparam int VL_W = 3;

  // Command queue sizing
  localparam int CQ_DEPTH = 8;
  localparam int CQ_PTR_W = 3;
  localparam int CQ_CNT_W = 4;

  // Issue capacity seen by the front end, 0 to NUM_SLOTS
  localparam int CAP_W = 2;

  typedef enum logic [2:0] {
    OP_VSETVL  = 3'd0,
    OP_VMV_VX  = 3'd1,
    OP_VADD_VV = 3'd2,
    OP_VSUB_VV = 3'd3,
    OP_VAND_VV = 3'd4,
    OP_VEXT_XV = 3'd5
  } rvv_op_e;

  // Configuration view of an instruction word
  typedef struct packed {
    rvv_op_e                op;
    logic [XREG_ADDR_W-1:0] rd;
    logic [23:0]            pad;
  } rvv_cfg_inst_t;

  // Vector view of an instruction word
  typedef struct packed {
    rvv_op_e                op;
    logic [VREG_IDX_W-1:0]  vd;
    logic [VREG_IDX_W-1:0]  vs1;
    logic [VREG_IDX_W-1:0]  vs2;
    logic [XREG_ADDR_W-1:0] rd;
    logic [14:0]            pad;
  } rvv_vec_inst_t;

  // Opcode sits in the top bits of both views
  typedef union packed {
    rvv_cfg_inst_t cfg;
    rvv_vec_inst_t vec;
  } rvv_inst_u;

  typedef struct packed {
    rvv_op_e                op;
    logic [VREG_IDX_W-1:0]  vd;
    logic [VREG_IDX_W-1:0]  vs1;
    logic [VREG_IDX_W-1:0]  vs2;
    logic [XREG_ADDR_W-1:0] rd;
    logic [ELEM_W-1:0]      scalar;
    logic [VL_W-1:0]        vl;
  } rvv_cmd_t;

  typedef struct packed {
    logic [VL_W-1:0] vl;
  } rvv_cfg_t;

  // Scalar register file write-back
  typedef struct packed {
    logic [XREG_ADDR_W-1:0] addr;
    logic [ELEM_W-1:0]      data;
  } rvv_xrf_wb_t;

endpackage

// ==== verilog/rvv_frontend.sv ====
module rvv_frontend (
  input  logic                                                 clk,
  input  logic                                                 arst_n_i,

  // Instruction slots from the scalar core
  input  logic [rvv_pkg::NUM_SLOTS-1:0]                        inst_valid_i,
  input  rvv_pkg::rvv_inst_u [rvv_pkg::NUM_SLOTS-1:0]          inst_data_i,
  output logic [rvv_pkg::NUM_SLOTS-1:0]                        inst_ready_o,
  input  logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::ELEM_W-1:0]   reg_read_data_i,

  // Free issue slots granted by the command queue
  input  logic [rvv_pkg::CAP_W-1:0]                            queue_capacity_i,

  output logic [rvv_pkg::NUM_SLOTS-1:0]                        cmd_valid_o,
  output rvv_pkg::rvv_cmd_t [rvv_pkg::NUM_SLOTS-1:0]           cmd_data_o,

  // Configuration results
  output logic [rvv_pkg::NUM_SLOTS-1:0]                        reg_write_valid_o,
  output rvv_pkg::rvv_xrf_wb_t [rvv_pkg::NUM_SLOTS-1:0]        reg_write_o,
  output logic                                                 config_state_valid_o,
  output rvv_pkg::rvv_cfg_t                                    config_state_o
);

  logic [rvv_pkg::NUM_SLOTS-1:0]                    is_cfg;
  logic [rvv_pkg::NUM_SLOTS-1:0]                    fire;
  logic [rvv_pkg::NUM_SLOTS-1:0]                    cfg_fire;
  logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::VL_W-1:0] cfg_vl;
  // Length as seen by each slot, chained through earlier configs
  logic [rvv_pkg::NUM_SLOTS:0][rvv_pkg::VL_W-1:0]   vl_chain;
  logic [rvv_pkg::VL_W-1:0]                         vl_q;

  always_comb begin
    logic [rvv_pkg::CAP_W-1:0] vec_used;
    logic                      prev_ok;

    vec_used = '0;
    prev_ok = 1'b1;
    vl_chain[0] = vl_q;
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      is_cfg[s] = (inst_data_i[s].cfg.op == rvv_pkg::OP_VSETVL);

      // Config needs no queue space, vector ops consume one entry each
      inst_ready_o[s] = prev_ok &&
                        ((inst_valid_i[s] && is_cfg[s]) || (vec_used < queue_capacity_i));
      fire[s] = inst_valid_i[s] && inst_ready_o[s];
      cfg_fire[s] = fire[s] && is_cfg[s];

      // vl = min(AVL, VLMAX)
      if (reg_read_data_i[s] > rvv_pkg::VLMAX) begin
        cfg_vl[s] = rvv_pkg::VL_W'(rvv_pkg::VLMAX);
      end else begin
        cfg_vl[s] = reg_read_data_i[s][rvv_pkg::VL_W-1:0];
      end
      vl_chain[s+1] = cfg_fire[s] ? cfg_vl[s] : vl_chain[s];

      cmd_valid_o[s] = fire[s] && !is_cfg[s];
      cmd_data_o[s].op = inst_data_i[s].vec.op;
      cmd_data_o[s].vd = inst_data_i[s].vec.vd;
      cmd_data_o[s].vs1 = inst_data_i[s].vec.vs1;
      cmd_data_o[s].vs2 = inst_data_i[s].vec.vs2;
      cmd_data_o[s].rd = inst_data_i[s].vec.rd;
      cmd_data_o[s].scalar = reg_read_data_i[s];
      cmd_data_o[s].vl = vl_chain[s];

      if (cmd_valid_o[s]) begin
        vec_used = vec_used + 1'b1;
      end
      // Keep acceptance in program order
      prev_ok = fire[s];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vl_q <= rvv_pkg::VL_W'(rvv_pkg::VLMAX);
      reg_write_valid_o <= '0;
      config_state_valid_o <= 1'b0;
    end else begin
      vl_q <= vl_chain[rvv_pkg::NUM_SLOTS];
      reg_write_valid_o <= cfg_fire;
      // Strobe whenever vl is written
      config_state_valid_o <= |cfg_fire;
    end
  end

  // Write-back payload returns the granted length
  always_ff @(posedge clk) begin
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      if (cfg_fire[s]) begin
        reg_write_o[s].addr <= inst_data_i[s].cfg.rd;
        reg_write_o[s].data <= rvv_pkg::ELEM_W'(cfg_vl[s]);
      end
    end
  end

  assign config_state_o.vl = vl_q;

endmodule

// ==== verilog/rvv_cmd_queue.sv ====
module rvv_cmd_queue (
  input  logic                                        clk,
  input  logic                                        arst_n_i,

  // Up to NUM_SLOTS pushes per cycle, slot 0 first
  input  logic [rvv_pkg::NUM_SLOTS-1:0]               push_valid_i,
  input  rvv_pkg::rvv_cmd_t [rvv_pkg::NUM_SLOTS-1:0]  push_cmd_i,

  input  logic                                        pop_i,
  output logic                                        head_valid_o,
  output rvv_pkg::rvv_cmd_t                           head_cmd_o,

  output logic [rvv_pkg::CQ_CNT_W-1:0]                remaining_count_o
);

  rvv_pkg::rvv_cmd_t mem_q [rvv_pkg::CQ_DEPTH];

  logic [rvv_pkg::CQ_PTR_W-1:0]                        wr_ptr_q;
  logic [rvv_pkg::CQ_PTR_W-1:0]                        rd_ptr_q;
  logic [rvv_pkg::CQ_CNT_W-1:0]                        count_q;
  logic [rvv_pkg::CQ_CNT_W-1:0]                        count_d;
  logic [rvv_pkg::CQ_CNT_W-1:0]                        push_num;
  logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::CQ_PTR_W-1:0] wr_idx;
  logic                                                pop;

  assign head_valid_o = (count_q != '0);
  assign head_cmd_o = mem_q[rd_ptr_q];
  assign pop = pop_i && head_valid_o;

  // Pack valid slots into consecutive entries
  always_comb begin
    push_num = '0;
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      wr_idx[s] = wr_ptr_q + push_num[rvv_pkg::CQ_PTR_W-1:0];
      push_num = push_num + rvv_pkg::CQ_CNT_W'(push_valid_i[s]);
    end
    count_d = count_q + push_num - rvv_pkg::CQ_CNT_W'(pop);
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      if (push_valid_i[s]) begin
        mem_q[wr_idx[s]] <= push_cmd_i[s];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      // Zero until the first count is registered
      remaining_count_o <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + push_num[rvv_pkg::CQ_PTR_W-1:0];
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_d;
      remaining_count_o <= rvv_pkg::CQ_CNT_W'(rvv_pkg::CQ_DEPTH) - count_d;
    end
  end

endmodule

// ==== verilog/rvv_backend.sv ====
module rvv_backend (
  input  logic                   clk,
  input  logic                   arst_n_i,

  // Head of the command queue
  input  logic                   head_valid_i,
  input  rvv_pkg::rvv_cmd_t      head_cmd_i,
  output logic                   pop_o,

  // Extract results back to the scalar core
  output logic                   async_rd_valid_o,
  output rvv_pkg::rvv_xrf_wb_t   async_rd_o,
  input  logic                   async_rd_ready_i
);

  logic [rvv_pkg::NUM_VREGS-1:0][rvv_pkg::VLMAX-1:0][rvv_pkg::ELEM_W-1:0] vrf_q;

  logic [rvv_pkg::VLMAX-1:0][rvv_pkg::ELEM_W-1:0] src1;
  logic [rvv_pkg::VLMAX-1:0][rvv_pkg::ELEM_W-1:0] src2;
  logic [rvv_pkg::VLMAX-1:0][rvv_pkg::ELEM_W-1:0] result;
  logic                                           writes_vd;
  logic                                           is_ext;

  // Stall while an extract result waits for the scalar core
  assign pop_o = head_valid_i && !async_rd_valid_o;

  assign src1 = vrf_q[head_cmd_i.vs1];
  assign src2 = vrf_q[head_cmd_i.vs2];
  assign is_ext = (head_cmd_i.op == rvv_pkg::OP_VEXT_XV);

  always_comb begin
    case (head_cmd_i.op)
      rvv_pkg::OP_VMV_VX,
      rvv_pkg::OP_VADD_VV,
      rvv_pkg::OP_VSUB_VV,
      rvv_pkg::OP_VAND_VV: writes_vd = 1'b1;
      default:             writes_vd = 1'b0;
    endcase
  end

  // Element-wise datapath
  always_comb begin
    for (int e = 0; e < rvv_pkg::VLMAX; e++) begin
      case (head_cmd_i.op)
        rvv_pkg::OP_VMV_VX:  result[e] = head_cmd_i.scalar;
        rvv_pkg::OP_VADD_VV: result[e] = src1[e] + src2[e];
        rvv_pkg::OP_VSUB_VV: result[e] = src1[e] - src2[e];
        rvv_pkg::OP_VAND_VV: result[e] = src1[e] & src2[e];
        default:             result[e] = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vrf_q <= '0;
      async_rd_valid_o <= 1'b0;
    end else begin
      if (pop_o && writes_vd) begin
        // Tail elements keep their old contents
        for (int e = 0; e < rvv_pkg::VLMAX; e++) begin
          if (e < head_cmd_i.vl) begin
            vrf_q[head_cmd_i.vd][e] <= result[e];
          end
        end
      end

      if (pop_o && is_ext) begin
        async_rd_valid_o <= 1'b1;
      end else if (async_rd_ready_i) begin
        async_rd_valid_o <= 1'b0;
      end
    end
  end

  // Extract ignores vl, index taken from the low scalar bits
  always_ff @(posedge clk) begin
    if (pop_o && is_ext) begin
      async_rd_o.addr <= head_cmd_i.rd;
      async_rd_o.data <= src2[head_cmd_i.scalar[rvv_pkg::ELEM_IDX_W-1:0]];
    end
  end

endmodule

// ==== verilog/rvv_core.sv ====
module rvv_core (
  input  logic                                                 clk,
  input  logic                                                 arst_n_i,

  // Instruction input
  input  logic [rvv_pkg::NUM_SLOTS-1:0]                        inst_valid_i,
  input  rvv_pkg::rvv_inst_u [rvv_pkg::NUM_SLOTS-1:0]          inst_data_i,
  output logic [rvv_pkg::NUM_SLOTS-1:0]                        inst_ready_o,
  input  logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::ELEM_W-1:0]   reg_read_data_i,

  // Scalar write-back for configuration
  output logic [rvv_pkg::NUM_SLOTS-1:0]                        reg_write_valid_o,
  output rvv_pkg::rvv_xrf_wb_t [rvv_pkg::NUM_SLOTS-1:0]        reg_write_o,

  // Scalar write-back for extracts
  output logic                                                 async_rd_valid_o,
  output rvv_pkg::rvv_xrf_wb_t                                 async_rd_o,
  input  logic                                                 async_rd_ready_i,

  output logic                                                 config_state_valid_o,
  output rvv_pkg::rvv_cfg_t                                    config_state_o
);

  logic [rvv_pkg::NUM_SLOTS-1:0]              cmd_valid;
  rvv_pkg::rvv_cmd_t [rvv_pkg::NUM_SLOTS-1:0] cmd_data;
  logic [rvv_pkg::CQ_CNT_W-1:0]               remaining_count;
  logic [rvv_pkg::CAP_W-1:0]                  queue_capacity;
  logic                                       head_valid;
  rvv_pkg::rvv_cmd_t                          head_cmd;
  logic                                       pop;

  // Front end never needs more than one entry per slot
  always_comb begin
    if (remaining_count > rvv_pkg::CQ_CNT_W'(rvv_pkg::NUM_SLOTS)) begin
      queue_capacity = rvv_pkg::CAP_W'(rvv_pkg::NUM_SLOTS);
    end else begin
      queue_capacity = remaining_count[rvv_pkg::CAP_W-1:0];
    end
  end

  rvv_frontend i_frontend (
    .clk                  (clk),
    .arst_n_i             (arst_n_i),
    .inst_valid_i         (inst_valid_i),
    .inst_data_i          (inst_data_i),
    .inst_ready_o         (inst_ready_o),
    .reg_read_data_i      (reg_read_data_i),
    .queue_capacity_i     (queue_capacity),
    .cmd_valid_o          (cmd_valid),
    .cmd_data_o           (cmd_data),
    .reg_write_valid_o    (reg_write_valid_o),
    .reg_write_o          (reg_write_o),
    .config_state_valid_o (config_state_valid_o),
    .config_state_o       (config_state_o)
  );

  rvv_cmd_queue i_cmd_queue (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .push_valid_i      (cmd_valid),
    .push_cmd_i        (cmd_data),
    .pop_i             (pop),
    .head_valid_o      (head_valid),
    .head_cmd_o        (head_cmd),
    .remaining_count_o (remaining_count)
  );

  rvv_backend i_backend (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .head_valid_i     (head_valid),
    .head_cmd_i       (head_cmd),
    .pop_o            (pop),
    .async_rd_valid_o (async_rd_valid_o),
    .async_rd_o       (async_rd_o),
    .async_rd_ready_i (async_rd_ready_i)
  );

endmodule

// ==== verif/rvv_core_tb.sv ====
module rvv_core_tb;

  // One table row: two slots offered together plus the extract ready pattern
  typedef struct packed {
    logic [2:0]                                               test;
    logic [1:0]                                               mode;
    logic [rvv_pkg::NUM_SLOTS-1:0]                            valid;
    rvv_pkg::rvv_inst_u [rvv_pkg::NUM_SLOTS-1:0]              inst;
    logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::ELEM_W-1:0]       opnd;
  } row_t;

  logic                                                clk;
  logic                                                arst_n_i;
  logic [rvv_pkg::NUM_SLOTS-1:0]                       inst_valid_i;
  rvv_pkg::rvv_inst_u [rvv_pkg::NUM_SLOTS-1:0]         inst_data_i;
  logic [rvv_pkg::NUM_SLOTS-1:0]                       inst_ready_o;
  logic [rvv_pkg::NUM_SLOTS-1:0][rvv_pkg::ELEM_W-1:0]  reg_read_data_i;
  logic [rvv_pkg::NUM_SLOTS-1:0]                       reg_write_valid_o;
  rvv_pkg::rvv_xrf_wb_t [rvv_pkg::NUM_SLOTS-1:0]       reg_write_o;
  logic                                                async_rd_valid_o;
  rvv_pkg::rvv_xrf_wb_t                                async_rd_o;
  logic                                                async_rd_ready_i;
  logic                                                config_state_valid_o;
  rvv_pkg::rvv_cfg_t                                   config_state_o;

  row_t                                                table_q[$];
  rvv_pkg::rvv_xrf_wb_t                                exp_q[$];
  // Reference copy of the vector registers and the vector length
  logic [rvv_pkg::ELEM_W-1:0]                          vreg [rvv_pkg::NUM_VREGS][rvv_pkg::VLMAX];
  int                                                  vl_m;
  logic [rvv_pkg::NUM_SLOTS-1:0]                       exp_wb_valid;
  rvv_pkg::rvv_xrf_wb_t [rvv_pkg::NUM_SLOTS-1:0]       exp_wb;
  logic                                                exp_cfg_valid;
  int                                                  test_err [6];
  int                                                  cycle_cnt;
  bit                                                  table_built = 1'b0;
  bit                                                  release_ready;
  bit                                                  saw_stall;

  rvv_core i_rvv_core (
    .clk                  (clk),
    .arst_n_i             (arst_n_i),
    .inst_valid_i         (inst_valid_i),
    .inst_data_i          (inst_data_i),
    .inst_ready_o         (inst_ready_o),
    .reg_read_data_i      (reg_read_data_i),
    .reg_write_valid_o    (reg_write_valid_o),
    .reg_write_o          (reg_write_o),
    .async_rd_valid_o     (async_rd_valid_o),
    .async_rd_o           (async_rd_o),
    .async_rd_ready_i     (async_rd_ready_i),
    .config_state_valid_o (config_state_valid_o),
    .config_state_o       (config_state_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic string test_name(int t);
    case (t)
      0:       return "reset";
      1:       return "vector length";
      2:       return "splat and extract";
      3:       return "arithmetic";
      4:       return "dual issue";
      default: return "back-pressure";
    endcase
  endfunction

  function automatic rvv_pkg::rvv_inst_u cfg_word(int rd);
    rvv_pkg::rvv_inst_u w;
    w = '0;
    w.cfg.op = rvv_pkg::OP_VSETVL;
    w.cfg.rd = 5'(rd);
    return w;
  endfunction

  function automatic rvv_pkg::rvv_inst_u vec_word(rvv_pkg::rvv_op_e op, int vd, int vs1,
                                                  int vs2, int rd);
    rvv_pkg::rvv_inst_u w;
    w = '0;
    w.vec.op = op;
    w.vec.vd = 3'(vd);
    w.vec.vs1 = 3'(vs1);
    w.vec.vs2 = 3'(vs2);
    w.vec.rd = 5'(rd);
    return w;
  endfunction

  task automatic add_row(int test, int mode, logic [1:0] valid, rvv_pkg::rvv_inst_u w0,
                         logic [31:0] d0, rvv_pkg::rvv_inst_u w1, logic [31:0] d1);
    row_t r;
    r.test = 3'(test);
    r.mode = 2'(mode);
    r.valid = valid;
    r.inst[0] = w0;
    r.inst[1] = w1;
    r.opnd[0] = d0;
    r.opnd[1] = d1;
    table_q.push_back(r);
  endtask

  // Mode 0 keeps ready high, 1 holds it low until a stall, 2 is random
  task automatic build_table();
    add_row(1, 0, 2'b01, cfg_word(5), 9, '0, 0);
    add_row(1, 0, 2'b01, cfg_word(6), 2, '0, 0);
    add_row(1, 0, 2'b11, cfg_word(7), 9, cfg_word(8), 3);
    add_row(2, 0, 2'b11, cfg_word(1), 4, vec_word(rvv_pkg::OP_VMV_VX, 1, 0, 0, 0), 32'h1111_1111);
    add_row(2, 0, 2'b11, cfg_word(1), 2, vec_word(rvv_pkg::OP_VMV_VX, 1, 0, 0, 0), 32'haaaa_5555);
    for (int i = 0; i < 4; i += 2) begin
      add_row(2, 0, 2'b11, vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 1, 10 + i), i,
              vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 1, 11 + i), i + 1);
    end
    add_row(3, 0, 2'b11, cfg_word(2), 4, vec_word(rvv_pkg::OP_VMV_VX, 2, 0, 0, 0), 32'h0f0f_1234);
    add_row(3, 0, 2'b11, vec_word(rvv_pkg::OP_VMV_VX, 3, 0, 0, 0), 32'h00ff_0101, cfg_word(2), 3);
    add_row(3, 0, 2'b11, vec_word(rvv_pkg::OP_VADD_VV, 4, 2, 3, 0), 0,
            vec_word(rvv_pkg::OP_VSUB_VV, 5, 3, 2, 0), 0);
    add_row(3, 0, 2'b01, vec_word(rvv_pkg::OP_VAND_VV, 6, 2, 3, 0), 0, '0, 0);
    for (int v = 4; v <= 6; v++) begin
      for (int i = 0; i < 4; i += 2) begin
        add_row(3, 0, 2'b11, vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, v, v + i), i,
                vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, v, v + i + 1), i + 1);
      end
    end
    // New length must reach the splat in slot 1 of the same cycle
    add_row(4, 0, 2'b11, cfg_word(3), 1, vec_word(rvv_pkg::OP_VMV_VX, 7, 0, 0, 0), 32'h7777_0001);
    add_row(4, 0, 2'b11, vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 7, 20), 0,
            vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 7, 21), 1);
    for (int k = 0; k < 24; k += 2) begin
      add_row(5, (k < 12) ? 1 : 2, 2'b11,
              vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 1 + k % 6, k + 1), k % 4,
              vec_word(rvv_pkg::OP_VEXT_XV, 0, 0, 1 + (k + 1) % 6, k + 2), (k + 1) % 4);
    end
  endtask

  task automatic report_mismatch(int t, string what, logic [63:0] got, logic [63:0] exp);
    $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    test_err[t]++;
  endtask

  task automatic report_fault(int t, string what);
    $display("Error at %0t: %s", $time, what);
    test_err[t]++;
  endtask

  // Model update for one accepted instruction
  task automatic accept(rvv_pkg::rvv_inst_u w, logic [31:0] d, int s);
    logic [31:0]          a;
    logic [31:0]          b;
    rvv_pkg::rvv_xrf_wb_t e;
    if (w.cfg.op == rvv_pkg::OP_VSETVL) begin
      vl_m = (d > rvv_pkg::VLMAX) ? rvv_pkg::VLMAX : int'(d);
      exp_wb_valid[s] = 1'b1;
      exp_wb[s].addr = w.cfg.rd;
      exp_wb[s].data = vl_m;
      exp_cfg_valid = 1'b1;
    end else if (w.vec.op == rvv_pkg::OP_VEXT_XV) begin
      e.addr = w.vec.rd;
      e.data = vreg[w.vec.vs2][d[1:0]];
      exp_q.push_back(e);
    end else begin
      for (int i = 0; i < vl_m; i++) begin
        a = vreg[w.vec.vs1][i];
        b = vreg[w.vec.vs2][i];
        case (w.vec.op)
          rvv_pkg::OP_VMV_VX:  vreg[w.vec.vd][i] = d;
          rvv_pkg::OP_VADD_VV: vreg[w.vec.vd][i] = a + b;
          rvv_pkg::OP_VSUB_VV: vreg[w.vec.vd][i] = a - b;
          default:             vreg[w.vec.vd][i] = a & b;
        endcase
      end
    end
  endtask

  // One clock: drive on the falling edge, check at the rising edge
  task automatic step(inout row_t r);
    logic [rvv_pkg::NUM_SLOTS-1:0] acc;
    @(negedge clk);
    inst_valid_i = r.valid;
    inst_data_i = r.inst;
    reg_read_data_i = r.opnd;
    case (r.mode)
      2'd1:    async_rd_ready_i = release_ready;
      2'd2:    async_rd_ready_i = 1'($urandom % 2);
      default: async_rd_ready_i = 1'b1;
    endcase
    @(posedge clk);
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      assert (reg_write_valid_o[s] == exp_wb_valid[s])
        else report_mismatch(r.test, "reg_write_valid_o", reg_write_valid_o[s], exp_wb_valid[s]);
      if (exp_wb_valid[s]) begin
        assert (reg_write_o[s] == exp_wb[s])
          else report_mismatch(r.test, "reg_write_o", reg_write_o[s], exp_wb[s]);
      end
    end
    assert (config_state_valid_o == exp_cfg_valid)
      else report_mismatch(r.test, "config_state_valid_o", config_state_valid_o, exp_cfg_valid);
    assert (config_state_o.vl == vl_m)
      else report_mismatch(r.test, "config_state_o.vl", config_state_o.vl, vl_m);
    if (async_rd_valid_o && async_rd_ready_i) begin
      assert (exp_q.size() != 0)
        else report_fault(r.test, "extract result returned with none outstanding");
      if (exp_q.size() != 0) begin
        assert (async_rd_o == exp_q[0])
          else report_mismatch(r.test, "async_rd_o", async_rd_o, exp_q[0]);
        void'(exp_q.pop_front());
      end
    end
    acc = inst_valid_i & inst_ready_o;
    assert (!(acc[1] && !acc[0])) else report_fault(r.test, "slot 1 accepted ahead of slot 0");
    if (inst_valid_i[0] && !inst_ready_o[0] && r.mode != 2'd0) begin
      saw_stall = 1'b1;
      release_ready = 1'b1;
    end
    exp_wb_valid = '0;
    exp_cfg_valid = 1'b0;
    for (int s = 0; s < rvv_pkg::NUM_SLOTS; s++) begin
      if (acc[s]) begin
        accept(r.inst[s], r.opnd[s], s);
      end
    end
    // Retry what was not taken, oldest in slot 0
    if (acc[0]) begin
      r.valid[0] = r.valid[1] && !acc[1];
      r.inst[0] = r.inst[1];
      r.opnd[0] = r.opnd[1];
      r.valid[1] = 1'b0;
    end
  endtask

  task automatic finish_test(int t);
    row_t idle;
    idle = '0;
    idle.test = 3'(t);
    while (exp_q.size() != 0) begin
      step(idle);
    end
    // Trailing config strobes land one edge later
    step(idle);
    if (t == 5) begin
      assert (saw_stall) else report_fault(t, "inst_ready_o never fell during the burst");
    end
    $display("Test %0d (%s): %s with %0d errors", t, test_name(t),
             (test_err[t] == 0) ? "passed" : "failed", test_err[t]);
  endtask

  initial begin
    cycle_cnt = 0;
    wait (table_built);
    while (cycle_cnt < 2 * table_q.size() + 200) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_cnt);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    row_t r;
    int   cur;
    int   npass;
    int   nfail;
    void'($urandom(32'h6b7c));
    arst_n_i = 1'b0;
    inst_valid_i = '0;
    inst_data_i = '0;
    reg_read_data_i = '0;
    async_rd_ready_i = 1'b1;
    vl_m = rvv_pkg::VLMAX;
    exp_wb_valid = '0;
    exp_wb = '0;
    exp_cfg_valid = 1'b0;
    saw_stall = 1'b0;
    release_ready = 1'b0;
    foreach (vreg[v, e]) vreg[v][e] = '0;
    foreach (test_err[t]) test_err[t] = 0;
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;
    @(posedge clk);
    // Free count not registered yet, so no slot may be ready
    assert (inst_ready_o == '0) else report_mismatch(0, "inst_ready_o", inst_ready_o, 0);
    assert ({reg_write_valid_o, config_state_valid_o, async_rd_valid_o} == '0)
      else report_fault(0, "a strobe is high right after reset");
    assert (config_state_o.vl == rvv_pkg::VLMAX)
      else report_mismatch(0, "config_state_o.vl", config_state_o.vl, rvv_pkg::VLMAX);
    cur = 0;
    foreach (table_q[i]) begin
      r = table_q[i];
      if (r.test != cur) begin
        finish_test(cur);
        cur = r.test;
      end
      release_ready = 1'b0;
      while (r.valid[0]) begin
        step(r);
      end
    end
    finish_test(cur);
    npass = 0;
    nfail = 0;
    foreach (test_err[t]) begin
      if (test_err[t] == 0) npass++;
      else nfail++;
    end
    $display("Tests passed: %0d, tests failed: %0d", npass, nfail);
    if (nfail == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/rvv_pkg.sv
verilog/rvv_frontend.sv
verilog/rvv_cmd_queue.sv
verilog/rvv_backend.sv
verilog/rvv_core.sv
verif/rvv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rvv_core

sources:
  # RTL in compile order
  - verilog/rvv_pkg.sv
  - verilog/rvv_frontend.sv
  - verilog/rvv_cmd_queue.sv
  - verilog/rvv_backend.sv
  - verilog/rvv_core.sv

  # Testbench
  - target: test
    files:
      - verif/rvv_core_tb.sv
